// File: hw/decode_reg.sv
`timescale 1ns/1ps

module decode_reg (
    input  logic  clk,
    input  logic  rst_i,
    id_bus_if.snk in_i,
    id_bus_if.src out_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_o.valid <= 1'b0;
        end else begin
            out_o.valid <= in_i.valid;
        end
    end

    // payload lines up with the regfile read issued this cycle
    always_ff @(posedge clk) begin
        out_o.invalid       <= in_i.invalid;
        out_o.aluop         <= in_i.aluop;
        out_o.alusel        <= in_i.alusel;
        out_o.raddr1        <= in_i.raddr1;
        out_o.raddr2        <= in_i.raddr2;
        out_o.re1           <= in_i.re1;
        out_o.re2           <= in_i.re2;
        out_o.imm           <= in_i.imm;
        out_o.waddr         <= in_i.waddr;
        out_o.we            <= in_i.we;
        out_o.jump_kind     <= in_i.jump_kind;
        out_o.direct_target <= in_i.direct_target;
        out_o.return_addr   <= in_i.return_addr;
    end

    // the resolver gates every control output on valid
    a_valid_known: assert property (
        @(posedge clk) disable iff (rst_i) !$isunknown(out_o.valid)
    ) else $error("buffered valid is unknown");

endmodule

// File: hw/id_bus_if.sv
`timescale 1ns/1ps

interface id_bus_if;
    import id_pkg::*;

    logic                  valid;
    logic                  invalid;      // unknown encoding
    alu_op_e               aluop;
    alu_sel_e              alusel;
    logic [REG_ADDR_W-1:0] raddr1;
    logic [REG_ADDR_W-1:0] raddr2;
    logic                  re1;
    logic                  re2;
    logic [DATA_W-1:0]     imm;          // stands in for a disabled read
    logic [REG_ADDR_W-1:0] waddr;
    logic                  we;
    jump_kind_e            jump_kind;
    logic [DATA_W-1:0]     direct_target;
    logic [DATA_W-1:0]     return_addr;

    modport src (
        output valid, invalid, aluop, alusel, raddr1, raddr2, re1, re2,
        output imm, waddr, we, jump_kind, direct_target, return_addr
    );

    modport snk (
        input valid, invalid, aluop, alusel, raddr1, raddr2, re1, re2,
        input imm, waddr, we, jump_kind, direct_target, return_addr
    );

endinterface

// File: hw/id_pkg.sv
package id_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;  // jal / jalr default target

    // primary opcode field, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // function field of special ops, inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_JR, ALU_JALR
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_JUMP
    } alu_sel_e;

    typedef enum logic [1:0] {
        JMP_NONE,
        JMP_DIRECT,    // target from the instr_index field
        JMP_REGISTER   // target from rs
    } jump_kind_e;

endpackage

// File: hw/id_stage_top.sv
`timescale 1ns/1ps

module id_stage_top #(
    parameter int PC_STEP = 1  // 1 word addressing, 4 byte addressing
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          inst_valid_i,
    input  logic [31:0]                   inst_i,
    input  logic [id_pkg::DATA_W-1:0]     pc_i,
    output logic [id_pkg::REG_ADDR_W-1:0] raddr1_o,
    output logic [id_pkg::REG_ADDR_W-1:0] raddr2_o,
    input  logic [id_pkg::DATA_W-1:0]     rdata1_i,
    input  logic [id_pkg::DATA_W-1:0]     rdata2_i,
    input  logic                          ex_we_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] ex_waddr_i,
    input  logic [id_pkg::DATA_W-1:0]     ex_wdata_i,
    input  logic                          mem_we_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] mem_waddr_i,
    input  logic [id_pkg::DATA_W-1:0]     mem_wdata_i,
    output logic                          valid_o,
    output logic                          inst_invalid_o,
    output id_pkg::alu_op_e               aluop_o,
    output id_pkg::alu_sel_e              alusel_o,
    output logic [id_pkg::DATA_W-1:0]     operand1_o,
    output logic [id_pkg::DATA_W-1:0]     operand2_o,
    output logic [id_pkg::REG_ADDR_W-1:0] waddr_o,
    output logic                          we_o,
    output logic                          branch_flag_o,
    output logic [id_pkg::DATA_W-1:0]     branch_target_o,
    output logic [id_pkg::DATA_W-1:0]     return_addr_o
);

    id_bus_if dec_bus ();
    id_bus_if buf_bus ();

    assign raddr1_o = dec_bus.raddr1;  // regfile answers next cycle
    assign raddr2_o = dec_bus.raddr2;

    inst_decoder #(
        .PC_STEP (PC_STEP)
    ) u_decoder (
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .dec_o        (dec_bus)
    );

    decode_reg u_decode_reg (
        .clk   (clk),
        .rst_i (rst_i),
        .in_i  (dec_bus),
        .out_o (buf_bus)
    );

    operand_resolver u_resolver (
        .clk             (clk),
        .rst_i           (rst_i),
        .item_i          (buf_bus),
        .rdata1_i        (rdata1_i),
        .rdata2_i        (rdata2_i),
        .ex_we_i         (ex_we_i),
        .ex_waddr_i      (ex_waddr_i),
        .ex_wdata_i      (ex_wdata_i),
        .mem_we_i        (mem_we_i),
        .mem_waddr_i     (mem_waddr_i),
        .mem_wdata_i     (mem_wdata_i),
        .valid_o         (valid_o),
        .inst_invalid_o  (inst_invalid_o),
        .aluop_o         (aluop_o),
        .alusel_o        (alusel_o),
        .operand1_o      (operand1_o),
        .operand2_o      (operand2_o),
        .waddr_o         (waddr_o),
        .we_o            (we_o),
        .branch_flag_o   (branch_flag_o),
        .branch_target_o (branch_target_o),
        .return_addr_o   (return_addr_o)
    );

endmodule

// File: hw/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder #(
    parameter int PC_STEP = 1
) (
    input  logic                      inst_valid_i,
    input  logic [31:0]               inst_i,
    input  logic [id_pkg::DATA_W-1:0] pc_i,
    id_bus_if.src                     dec_o
);
    import id_pkg::*;

    logic [5:0]            op;
    logic [4:0]            rs, rt, rd, sa;
    logic [5:0]            funct;
    logic [15:0]           imm16;
    logic [25:0]           instr_index;
    logic [DATA_W-1:0]     pc_next;

    alu_op_e               fn_op, i_op, aluop;
    alu_sel_e              alusel;
    logic                  re1, re2, we, known;
    logic [REG_ADDR_W-1:0] waddr;
    logic [DATA_W-1:0]     imm;
    jump_kind_e            jump_kind;

    assign op          = inst_i[31:26];
    assign rs          = inst_i[25:21];
    assign rt          = inst_i[20:16];
    assign rd          = inst_i[15:11];
    assign sa          = inst_i[10:6];
    assign funct       = inst_i[5:0];
    assign imm16       = inst_i[15:0];
    assign instr_index = inst_i[25:0];
    assign pc_next     = pc_i + DATA_W'(PC_STEP);

    always_comb begin
        case (funct)
            FN_SLL, FN_SLLV: fn_op = ALU_SLL;
            FN_SRL, FN_SRLV: fn_op = ALU_SRL;
            FN_SRA, FN_SRAV: fn_op = ALU_SRA;
            FN_AND:          fn_op = ALU_AND;
            FN_OR:           fn_op = ALU_OR;
            FN_XOR:          fn_op = ALU_XOR;
            FN_NOR:          fn_op = ALU_NOR;
            FN_ADD:          fn_op = ALU_ADD;
            FN_ADDU:         fn_op = ALU_ADDU;
            FN_SUB:          fn_op = ALU_SUB;
            FN_SUBU:         fn_op = ALU_SUBU;
            FN_SLT:          fn_op = ALU_SLT;
            FN_SLTU:         fn_op = ALU_SLTU;
            FN_JR:           fn_op = ALU_JR;
            FN_JALR:         fn_op = ALU_JALR;
            default:         fn_op = ALU_NOP;
        endcase
    end

    always_comb begin
        case (op)
            OP_ANDI:  i_op = ALU_AND;
            OP_ORI:   i_op = ALU_OR;
            OP_XORI:  i_op = ALU_XOR;
            OP_ADDI:  i_op = ALU_ADD;
            OP_ADDIU: i_op = ALU_ADDU;
            OP_SLTI:  i_op = ALU_SLT;
            OP_SLTIU: i_op = ALU_SLTU;
            default:  i_op = ALU_NOP;
        endcase
    end

    always_comb begin
        aluop     = ALU_NOP;
        alusel    = SEL_NOP;
        re1       = 1'b0;
        re2       = 1'b0;
        we        = 1'b0;
        known     = 1'b0;
        imm       = '0;
        waddr     = rt;  // i-type default
        jump_kind = JMP_NONE;
        case (op)
            OP_SPECIAL: begin
                aluop = fn_op;
                waddr = rd;
                we    = 1'b1;
                re1   = 1'b1;
                re2   = 1'b1;
                known = (sa == '0);
                case (funct)
                    FN_SLL, FN_SRL, FN_SRA: begin
                        re1    = 1'b0;
                        imm    = DATA_W'(sa);  // shift amount as operand 1
                        known  = (rs == '0);
                        alusel = SEL_SHIFT;
                    end
                    FN_SLLV, FN_SRLV, FN_SRAV: alusel = SEL_SHIFT;
                    FN_AND, FN_OR, FN_XOR, FN_NOR: alusel = SEL_LOGIC;
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU: alusel = SEL_ARITH;
                    FN_JR, FN_JALR: begin
                        re2       = 1'b0;
                        we        = (funct == FN_JALR);
                        waddr     = (rd != '0) ? rd : LINK_REG;
                        alusel    = SEL_JUMP;
                        jump_kind = JMP_REGISTER;
                    end
                    default: known = 1'b0;
                endcase
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                known  = 1'b1;
                we     = 1'b1;
                re1    = 1'b1;
                imm    = {16'h0000, imm16};  // zero extend
                aluop  = i_op;
                alusel = SEL_LOGIC;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                known  = 1'b1;
                we     = 1'b1;
                re1    = 1'b1;
                imm    = {{16{imm16[15]}}, imm16};  // sign extend
                aluop  = i_op;
                alusel = SEL_ARITH;
            end
            OP_LUI: begin
                known  = 1'b1;
                we     = 1'b1;
                imm    = {imm16, 16'h0000};
                aluop  = ALU_OR;
                alusel = SEL_LOGIC;
            end
            OP_J, OP_JAL: begin
                known     = 1'b1;
                we        = (op == OP_JAL);
                waddr     = LINK_REG;
                aluop     = (op == OP_JAL) ? ALU_JALR : ALU_JR;
                alusel    = SEL_JUMP;
                jump_kind = JMP_DIRECT;
            end
            default: ;
        endcase
        if (!known) begin  // unknown encodings collapse to a plain nop
            aluop     = ALU_NOP;
            alusel    = SEL_NOP;
            re1       = 1'b0;
            re2       = 1'b0;
            we        = 1'b0;
            imm       = '0;
            waddr     = '0;
            jump_kind = JMP_NONE;
        end
    end

    assign dec_o.valid     = inst_valid_i;
    assign dec_o.invalid   = ~known;
    assign dec_o.aluop     = aluop;
    assign dec_o.alusel    = alusel;
    assign dec_o.re1       = re1;
    assign dec_o.re2       = re2;
    assign dec_o.raddr1    = re1 ? rs : '0;  // port 1 always reads rs
    assign dec_o.raddr2    = re2 ? rt : '0;  // port 2 always reads rt
    assign dec_o.imm       = imm;
    assign dec_o.waddr     = waddr;
    assign dec_o.we        = we;
    assign dec_o.jump_kind = jump_kind;
    assign dec_o.direct_target = (PC_STEP == 4) ? {pc_next[31:28], instr_index, 2'b00}
                                                : {6'b000000, instr_index};
    assign dec_o.return_addr   = (aluop == ALU_JALR) ? pc_next : '0;

endmodule

// File: hw/operand_resolver.sv
`timescale 1ns/1ps

module operand_resolver (
    input  logic                          clk,
    input  logic                          rst_i,
    id_bus_if.snk                         item_i,
    input  logic [id_pkg::DATA_W-1:0]     rdata1_i,
    input  logic [id_pkg::DATA_W-1:0]     rdata2_i,
    input  logic                          ex_we_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] ex_waddr_i,
    input  logic [id_pkg::DATA_W-1:0]     ex_wdata_i,
    input  logic                          mem_we_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] mem_waddr_i,
    input  logic [id_pkg::DATA_W-1:0]     mem_wdata_i,
    output logic                          valid_o,
    output logic                          inst_invalid_o,
    output id_pkg::alu_op_e               aluop_o,
    output id_pkg::alu_sel_e              alusel_o,
    output logic [id_pkg::DATA_W-1:0]     operand1_o,
    output logic [id_pkg::DATA_W-1:0]     operand2_o,
    output logic [id_pkg::REG_ADDR_W-1:0] waddr_o,
    output logic                          we_o,
    output logic                          branch_flag_o,
    output logic [id_pkg::DATA_W-1:0]     branch_target_o,
    output logic [id_pkg::DATA_W-1:0]     return_addr_o
);
    import id_pkg::*;

    logic [DATA_W-1:0] op1, op2;
    logic [DATA_W-1:0] target;

    // priority is execute, then memory, then regfile data
    function automatic logic [DATA_W-1:0] pick_operand(
        input logic                  re,
        input logic [REG_ADDR_W-1:0] addr,
        input logic [DATA_W-1:0]     rdata,
        input logic [DATA_W-1:0]     imm
    );
        logic [DATA_W-1:0] res;
        if (!re) begin
            res = imm;
        end else if (addr == '0) begin
            res = '0;  // r0 never forwarded
        end else if (ex_we_i && ex_waddr_i == addr) begin
            res = ex_wdata_i;
        end else if (mem_we_i && mem_waddr_i == addr) begin
            res = mem_wdata_i;
        end else begin
            res = rdata;
        end
        return res;
    endfunction

    assign op1 = pick_operand(item_i.re1, item_i.raddr1, rdata1_i, item_i.imm);
    assign op2 = pick_operand(item_i.re2, item_i.raddr2, rdata2_i, item_i.imm);

    assign target = (item_i.jump_kind == JMP_DIRECT) ? item_i.direct_target : op1;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o        <= 1'b0;
            we_o           <= 1'b0;
            branch_flag_o  <= 1'b0;
            inst_invalid_o <= 1'b0;
        end else begin
            valid_o        <= item_i.valid;
            we_o           <= item_i.valid && item_i.we;
            branch_flag_o  <= item_i.valid && item_i.jump_kind != JMP_NONE;
            inst_invalid_o <= item_i.valid && item_i.invalid;
        end
    end

    always_ff @(posedge clk) begin
        aluop_o         <= item_i.aluop;
        alusel_o        <= item_i.alusel;
        operand1_o      <= op1;
        operand2_o      <= op2;
        waddr_o         <= item_i.waddr;
        branch_target_o <= target;
        return_addr_o   <= item_i.return_addr;
    end

    // an invalid item must arrive with its jump and write stripped
    a_branch_valid: assert property (
        @(posedge clk) disable iff (rst_i) branch_flag_o |-> valid_o && !inst_invalid_o
    ) else $error("branch flag without a valid, known item");

    a_write_known: assert property (
        @(posedge clk) disable iff (rst_i) we_o |-> !inst_invalid_o
    ) else $error("write enable on an invalid item");

endmodule

// File: mips_id.f
hw/id_pkg.sv
hw/id_bus_if.sv
hw/inst_decoder.sv
hw/decode_reg.sv
hw/operand_resolver.sv
hw/id_stage_top.sv
verification/id_checker.sv
verification/tb_id_stage.sv

// File: run_sim.sh
#!/bin/bash
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_id_stage \
    -f mips_id.f -o sim_id_stage || exit 1

./obj_dir/sim_id_stage > sim.log 2>&1
cat sim.log

grep -q "Something failed" sim.log && echo "simulation FAILED" && exit 1
grep -q "Everything OK" sim.log && echo "simulation passed" && exit 0 || exit 1

// File: verification/id_checker.sv
`timescale 1ns/1ps

module id_checker (
    input logic        clk,
    input logic        rst_i,
    input logic        inst_valid_i,
    input logic [31:0] inst_i,
    input logic [31:0] pc_i,
    input logic [31:0] regs_i [32],
    input logic        ex_we_i,
    input logic [4:0]  ex_waddr_i,
    input logic [31:0] ex_wdata_i,
    input logic        mem_we_i,
    input logic [4:0]  mem_waddr_i,
    input logic [31:0] mem_wdata_i,
    input logic        valid_o,
    input logic        inst_invalid_o,
    input logic [4:0]  aluop_o,
    input logic [2:0]  alusel_o,
    input logic [31:0] operand1_o,
    input logic [31:0] operand2_o,
    input logic [4:0]  waddr_o,
    input logic        we_o,
    input logic        branch_flag_o,
    input logic [31:0] branch_target_o,
    input logic [31:0] return_addr_o
);
    import id_pkg::*;

    typedef struct packed {
        logic        invalid;
        logic [4:0]  aluop;
        logic [2:0]  alusel;
        logic [31:0] op1;
        logic [31:0] op2;
        logic [4:0]  waddr;
        logic        we;
        logic        branch;
        logic [31:0] target;
        logic [31:0] ret;
        logic [31:0] due;     // cycle in which valid_o must show
    } exp_t;

    exp_t        exp_q[$];
    logic        held_valid;
    logic [31:0] held_inst;
    logic [31:0] held_pc;
    int          cycle;
    int          err_cnt = 0;
    int          check_cnt = 0;
    int          valid_cnt = 0;
    int          outstanding = 0;

    // value an enabled source read should deliver
    function automatic logic [31:0] fwd_value(input logic [4:0] a);
        if (a == 5'd0)
            return 32'h0;
        if (ex_we_i && ex_waddr_i == a)
            return ex_wdata_i;
        if (mem_we_i && mem_waddr_i == a)
            return mem_wdata_i;
        return regs_i[a];
    endfunction

    function automatic exp_t ref_decode(input logic [31:0] inst, input logic [31:0] pc);
        exp_t        e;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic        ok;
        op = inst[31:26];
        fn = inst[5:0];
        rs = inst[25:21];
        rt = inst[20:16];
        rd = inst[15:11];
        sa = inst[10:6];
        e  = '0;
        ok = 1'b1;
        case (op)
            6'h00: begin
                e.waddr = rd;
                e.we    = 1'b1;
                e.op1   = fwd_value(rs);
                e.op2   = fwd_value(rt);
                ok      = (sa == 5'd0);
                case (fn)
                    6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07: begin
                        e.alusel = SEL_SHIFT;
                        e.aluop  = fn[1] ? (fn[0] ? ALU_SRA : ALU_SRL) : ALU_SLL;
                        if (!fn[2]) begin  // shift by sa
                            ok    = (rs == 5'd0);
                            e.op1 = {27'd0, sa};
                        end
                    end
                    6'h24: begin e.alusel = SEL_LOGIC; e.aluop = ALU_AND; end
                    6'h25: begin e.alusel = SEL_LOGIC; e.aluop = ALU_OR; end
                    6'h26: begin e.alusel = SEL_LOGIC; e.aluop = ALU_XOR; end
                    6'h27: begin e.alusel = SEL_LOGIC; e.aluop = ALU_NOR; end
                    6'h20: begin e.alusel = SEL_ARITH; e.aluop = ALU_ADD; end
                    6'h21: begin e.alusel = SEL_ARITH; e.aluop = ALU_ADDU; end
                    6'h22: begin e.alusel = SEL_ARITH; e.aluop = ALU_SUB; end
                    6'h23: begin e.alusel = SEL_ARITH; e.aluop = ALU_SUBU; end
                    6'h2a: begin e.alusel = SEL_ARITH; e.aluop = ALU_SLT; end
                    6'h2b: begin e.alusel = SEL_ARITH; e.aluop = ALU_SLTU; end
                    6'h08, 6'h09: begin
                        e.alusel = SEL_JUMP;
                        e.aluop  = fn[0] ? ALU_JALR : ALU_JR;
                        e.op2    = 32'h0;
                        e.we     = fn[0];
                        e.waddr  = (rd != 5'd0) ? rd : 5'd31;
                        e.branch = 1'b1;
                        e.target = e.op1;
                        e.ret    = fn[0] ? pc + 32'd1 : 32'h0;
                    end
                    default: ok = 1'b0;
                endcase
            end
            6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e: begin
                e.we     = 1'b1;
                e.waddr  = rt;
                e.op1    = fwd_value(rs);
                e.op2    = op[2] ? {16'h0, inst[15:0]} : {{16{inst[15]}}, inst[15:0]};
                e.alusel = op[2] ? SEL_LOGIC : SEL_ARITH;
                case (op)
                    6'h08: e.aluop = ALU_ADD;
                    6'h09: e.aluop = ALU_ADDU;
                    6'h0a: e.aluop = ALU_SLT;
                    6'h0b: e.aluop = ALU_SLTU;
                    6'h0c: e.aluop = ALU_AND;
                    6'h0d: e.aluop = ALU_OR;
                    default: e.aluop = ALU_XOR;
                endcase
            end
            6'h0f: begin  // lui feeds both operands
                e.we     = 1'b1;
                e.waddr  = rt;
                e.op1    = {inst[15:0], 16'h0};
                e.op2    = {inst[15:0], 16'h0};
                e.alusel = SEL_LOGIC;
                e.aluop  = ALU_OR;
            end
            6'h02, 6'h03: begin
                e.we     = op[0];
                e.waddr  = 5'd31;
                e.alusel = SEL_JUMP;
                e.aluop  = op[0] ? ALU_JALR : ALU_JR;
                e.branch = 1'b1;
                e.target = {6'd0, inst[25:0]};
                e.ret    = op[0] ? pc + 32'd1 : 32'h0;
            end
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            e         = '0;
            e.invalid = 1'b1;
        end
        return e;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    always @(posedge clk) begin
        exp_t e;
        if (rst_i) begin
            held_valid = 1'b0;
            cycle      = 0;
            exp_q.delete();
        end else begin
            cycle++;
            if (held_valid) begin  // item sits in decode_reg now
                e     = ref_decode(held_inst, held_pc);
                e.due = cycle + 1;
                exp_q.push_back(e);
            end
            held_valid = inst_valid_i;
            held_inst  = inst_i;
            held_pc    = pc_i;
            if (inst_valid_i)
                outstanding++;
            if (valid_o) begin
                valid_cnt++;
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("valid_o pulsed with no instruction in flight");
                end else begin
                    e = exp_q.pop_front();
                    outstanding--;
                    if (e.due != cycle) begin
                        err_cnt++;
                        $display("valid_o arrived at the wrong cycle");
                    end
                    check_val("inst_invalid_o", inst_invalid_o, e.invalid);
                    check_val("aluop_o", aluop_o, e.aluop);
                    check_val("alusel_o", alusel_o, e.alusel);
                    check_val("operand1_o", operand1_o, e.op1);
                    check_val("operand2_o", operand2_o, e.op2);
                    check_val("waddr_o", waddr_o, e.waddr);
                    check_val("we_o", we_o, e.we);
                    check_val("branch_flag_o", branch_flag_o, e.branch);
                    check_val("return_addr_o", return_addr_o, e.ret);
                    if (e.branch)
                        check_val("branch_target_o", branch_target_o, e.target);
                end
            end else if (exp_q.size() > 0 && exp_q[0].due == cycle) begin
                e = exp_q.pop_front();
                outstanding--;
                err_cnt++;
                $display("valid_o missing for an issued instruction");
            end
        end
    end

endmodule

// File: verification/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;
    import id_pkg::*;

    logic        clk = 1'b0;
    logic        rst_i;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic [31:0] pc_i;
    logic [4:0]  raddr1_o;
    logic [4:0]  raddr2_o;
    logic [31:0] rdata1_i;
    logic [31:0] rdata2_i;
    logic        ex_we_i;
    logic [4:0]  ex_waddr_i;
    logic [31:0] ex_wdata_i;
    logic        mem_we_i;
    logic [4:0]  mem_waddr_i;
    logic [31:0] mem_wdata_i;
    logic        valid_o;
    logic        inst_invalid_o;
    alu_op_e     aluop_o;
    alu_sel_e    alusel_o;
    logic [31:0] operand1_o;
    logic [31:0] operand2_o;
    logic [4:0]  waddr_o;
    logic        we_o;
    logic        branch_flag_o;
    logic [31:0] branch_target_o;
    logic [31:0] return_addr_o;

    int          seed = 32'h9167;
    logic [31:0] regs [32];
    logic [31:0] pc = 32'h100;
    int          prev_err = 0;
    int          tb_errs = 0;
    int          start_cnt;
    logic [5:0]  reg_fns [10] = '{6'h24, 6'h25, 6'h26, 6'h27, 6'h20,
                                   6'h21, 6'h22, 6'h23, 6'h2a, 6'h2b};

    always #4 clk = ~clk;

    id_stage_top #(.PC_STEP(1)) u_dut (.*);

    id_checker u_chk (.regs_i(regs), .*);

    // register file with a one-cycle read
    always @(posedge clk) begin
        rdata1_i <= regs[raddr1_o];
        rdata2_i <= regs[raddr2_o];
    end

    function automatic logic [31:0] rtype(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sa,
                                          input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function logic [31:0] rand_regop();
        return rtype($random(seed), $random(seed), $random(seed), 5'd0,
                     reg_fns[($random(seed) & 32'h7fff) % 10]);
    endfunction

    function logic [31:0] rand_imm();
        logic [5:0] op;
        op = 6'h08 + 6'(($random(seed) & 32'h7fff) % 8);
        return {op, 26'($random(seed))};
    endfunction

    task automatic issue(input logic [31:0] inst);
        @(posedge clk);
        inst_valid_i <= 1'b1;
        inst_i       <= inst;
        pc_i         <= pc;
        pc = pc + 32'd1;
    endtask

    task automatic set_fwd(input logic ew, input logic [4:0] ea, input logic mw,
                           input logic [4:0] ma);
        @(posedge clk);
        inst_valid_i <= 1'b0;
        ex_we_i      <= ew;
        ex_waddr_i   <= ea;
        ex_wdata_i   <= $random(seed);
        mem_we_i     <= mw;
        mem_waddr_i  <= ma;
        mem_wdata_i  <= $random(seed);
    endtask

    task automatic finish_test(input string name);
        int t;
        @(posedge clk);
        inst_valid_i <= 1'b0;
        t = 0;
        @(negedge clk);
        while (u_chk.outstanding != 0 && t < 20) begin
            @(negedge clk);
            t++;
        end
        if (u_chk.outstanding != 0) begin
            tb_errs++;
            $display("test %s timed out with instructions still in flight", name);
        end else begin
            $display("test %s done, %0d errors", name, u_chk.err_cnt - prev_err);
        end
        prev_err = u_chk.err_cnt;
    endtask

    initial begin
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        rdata1_i     = '0;
        rdata2_i     = '0;
        ex_we_i      = 1'b0;
        ex_waddr_i   = '0;
        ex_wdata_i   = '0;
        mem_we_i     = 1'b0;
        mem_waddr_i  = '0;
        mem_wdata_i  = '0;
        for (int i = 0; i < 32; i++)
            regs[i] = $random(seed) | 32'h1;  // nonzero, so r0 must be masked
        repeat (10) @(posedge clk);
        rst_i <= 1'b0;
        repeat (5) @(posedge clk);  // valid_o must stay low here

        for (int i = 0; i < 30; i++)
            issue(rand_regop());
        issue(rtype(5'd0, 5'd0, 5'd4, 5'd0, 6'h20));
        finish_test("register ops");

        for (int i = 0; i < 30; i++)
            issue(rand_imm());
        finish_test("immediates");

        for (int i = 0; i < 20; i++) begin
            issue(rtype($random(seed), $random(seed), $random(seed), 5'd0, 6'h04 + (i % 4)));
            issue(rtype(5'd0, $random(seed), $random(seed), $random(seed), 6'h00 + (i % 4)));
        end
        finish_test("shifts");

        set_fwd(1'b1, 5'd5, 1'b1, 5'd5);  // same target, execute wins
        issue(rtype(5'd5, 5'd6, 5'd1, 5'd0, 6'h21));
        issue(rtype(5'd6, 5'd5, 5'd2, 5'd0, 6'h25));
        finish_test("forward same");
        set_fwd(1'b1, 5'd5, 1'b1, 5'd6);
        issue(rtype(5'd5, 5'd6, 5'd1, 5'd0, 6'h20));
        issue({6'h0c, 5'd6, 5'd3, 16'h1234});
        finish_test("forward split");
        set_fwd(1'b1, 5'd0, 1'b1, 5'd0);  // r0 writes are ignored
        issue(rtype(5'd0, 5'd0, 5'd1, 5'd0, 6'h26));
        finish_test("forward r0");

        set_fwd(1'b1, 5'd9, 1'b0, 5'd0);
        issue({6'h02, 26'($random(seed))});
        issue({6'h03, 26'($random(seed))});
        issue(rtype(5'd9, 5'd0, 5'd0, 5'd0, 6'h08));
        issue(rtype(5'd9, 5'd0, 5'd0, 5'd0, 6'h09));
        issue(rtype(5'd12, 5'd0, 5'd7, 5'd0, 6'h09));
        finish_test("jumps");

        issue(rtype(5'd1, 5'd2, 5'd0, 5'd0, 6'h18));  // mult
        issue(rtype(5'd1, 5'd2, 5'd0, 5'd0, 6'h19));  // multu
        issue({6'h1c, 5'd1, 5'd2, 5'd3, 5'd0, 6'h02});  // mul
        issue({6'h1c, 5'd1, 5'd2, 5'd3, 5'd0, 6'h20});  // clz
        issue({6'h1c, 5'd1, 5'd2, 5'd3, 5'd0, 6'h21});  // clo
        issue(rtype(5'd0, 5'd0, 5'd0, 5'd0, 6'h0f));  // sync
        issue({6'h33, 26'h0012345});  // pref
        issue(rtype(5'd1, 5'd2, 5'd3, 5'd4, 6'h20));  // add with nonzero sa
        finish_test("invalid");

        set_fwd(1'b1, $random(seed), 1'b1, $random(seed));
        start_cnt = u_chk.valid_cnt;
        for (int i = 0; i < 200; i++) begin
            case ($random(seed) & 3)
                0: issue($random(seed));
                1: issue(rand_regop());
                2: issue(rand_imm());
                default: issue(rtype(5'd0, $random(seed), $random(seed), $random(seed),
                                     6'($random(seed) & 3)));
            endcase
        end
        finish_test("stream");
        if (u_chk.valid_cnt - start_cnt != 200) begin
            tb_errs++;
            $display("stream gave %0d valid_o pulses instead of 200",
                     u_chk.valid_cnt - start_cnt);
        end

        $display("checks %0d, errors %0d, valid pulses %0d", u_chk.check_cnt,
                 u_chk.err_cnt + tb_errs, u_chk.valid_cnt);
        if (u_chk.err_cnt + tb_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
